// File: hw/aes_pkg.sv
package aes_pkg;

    typedef logic [127:0] aes_block_t;
    typedef logic [31:0]  aes_word_t;
    typedef logic [3:0]   aes_round_t;

    localparam aes_round_t AES_ROUNDS = 4'd10;

    // round key 0 is the cipher key itself
    typedef aes_block_t [AES_ROUNDS:0] aes_rkeys_t;

    // rcon for key schedule rounds 1 to 10
    localparam logic [1:AES_ROUNDS][7:0] AES_RCON = {
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ p;
            end
            p = xtime(p);
        end
        return acc;
    endfunction

    // a^254, which also maps zero to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] res;
        sq  = a;
        res = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            res = gf_mul(res, sq);
        end
        return res;
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
        return (b << n) | (b >> (8 - n));
    endfunction

    function automatic logic [7:0] sbox(input logic [7:0] b);
        logic [7:0] v;
        v = gf_inv(b);
        // affine transform
        return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
    endfunction

    function automatic logic [7:0] inv_sbox(input logic [7:0] b);
        return gf_inv(rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05);
    endfunction

    function automatic aes_block_t sub_bytes(input aes_block_t s);
        aes_block_t o;
        for (int i = 0; i < 16; i++) begin
            o[8 * i +: 8] = sbox(s[8 * i +: 8]);
        end
        return o;
    endfunction

    function automatic aes_block_t inv_sub_bytes(input aes_block_t s);
        aes_block_t o;
        for (int i = 0; i < 16; i++) begin
            o[8 * i +: 8] = inv_sbox(s[8 * i +: 8]);
        end
        return o;
    endfunction

    // byte k sits at row k % 4, column k / 4, msb first
    function automatic aes_block_t row_shift(input aes_block_t s, input logic inv);
        aes_block_t o;
        int         src_col;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                src_col = inv ? (c + 4 - r) % 4 : (c + r) % 4;
                o[127 - 8 * (4 * c + r) -: 8] = s[127 - 8 * (4 * src_col + r) -: 8];
            end
        end
        return o;
    endfunction

    function automatic aes_block_t shift_rows(input aes_block_t s);
        return row_shift(s, 1'b0);
    endfunction

    function automatic aes_block_t inv_shift_rows(input aes_block_t s);
        return row_shift(s, 1'b1);
    endfunction

    // one column times the circulant matrix whose first row is coef
    function automatic aes_word_t mix_word(input aes_word_t w, input aes_word_t coef);
        aes_word_t  o;
        logic [7:0] acc;
        for (int r = 0; r < 4; r++) begin
            acc = 8'h00;
            for (int j = 0; j < 4; j++) begin
                acc = acc ^ gf_mul(coef[31 - 8 * ((j - r + 4) % 4) -: 8], w[31 - 8 * j -: 8]);
            end
            o[31 - 8 * r -: 8] = acc;
        end
        return o;
    endfunction

    function automatic aes_block_t mix_block(input aes_block_t s, input aes_word_t coef);
        aes_block_t o;
        for (int c = 0; c < 4; c++) begin
            o[127 - 32 * c -: 32] = mix_word(s[127 - 32 * c -: 32], coef);
        end
        return o;
    endfunction

    function automatic aes_block_t mix_columns(input aes_block_t s);
        return mix_block(s, 32'h02030101);
    endfunction

    function automatic aes_block_t inv_mix_columns(input aes_block_t s);
        return mix_block(s, 32'h0e0b0d09);
    endfunction

    function automatic aes_word_t sub_word(input aes_word_t w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    function automatic aes_word_t rot_word(input aes_word_t w);
        return {w[23:0], w[31:24]};
    endfunction

endpackage

// File: hw/aes128_key_expand.sv
`timescale 1ns/1ps

module aes128_key_expand
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       load_i,
    input  aes_block_t key_i,

    output aes_rkeys_t round_keys_o,
    output logic       busy_o
);

    aes_rkeys_t rkeys_q;
    // index of the round key written on the next edge, stays in 1..10
    aes_round_t rnd_q;
    logic       busy_q;

    aes_block_t prev_key;
    aes_word_t  temp;
    aes_block_t next_key;

    always_comb begin
        prev_key = rkeys_q[rnd_q - 4'd1];
        temp     = sub_word(rot_word(prev_key[31:0])) ^ {AES_RCON[rnd_q], 24'h000000};
        // each word chains off the one before it
        next_key[127:96] = prev_key[127:96] ^ temp;
        next_key[95:64]  = prev_key[95:64]  ^ next_key[127:96];
        next_key[63:32]  = prev_key[63:32]  ^ next_key[95:64];
        next_key[31:0]   = prev_key[31:0]   ^ next_key[63:32];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rkeys_q <= '0;
            rnd_q   <= 4'd1;
            busy_q  <= 1'b0;
        end else if (load_i) begin
            rkeys_q[0] <= key_i;
            rnd_q      <= 4'd1;
            busy_q     <= 1'b1;
        end else if (busy_q) begin
            rkeys_q[rnd_q] <= next_key;
            if (rnd_q == AES_ROUNDS) begin
                // round key 10 written, schedule complete
                busy_q <= 1'b0;
            end else begin
                rnd_q <= rnd_q + 4'd1;
            end
        end
    end

    assign round_keys_o = rkeys_q;
    assign busy_o       = busy_q;

    // the core must hold off a new key until expansion finishes
    a_no_load_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy_o |-> !load_i
    ) else $error("key load issued during key expansion");

endmodule

// File: hw/aes128_encrypt.sv
`timescale 1ns/1ps

module aes128_encrypt
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       start_i,
    input  aes_rkeys_t round_keys_i,
    input  aes_block_t plain_text_i,

    output aes_block_t cipher_text_o,
    output logic       done_o,
    output logic       ready_o
);

    aes_block_t state_q;
    // 0 when idle, otherwise the round performed on the next edge
    aes_round_t rnd_q;
    logic       done_q;

    aes_block_t shifted;
    aes_block_t round_out;

    always_comb begin
        shifted = shift_rows(sub_bytes(state_q));
        // last round has no mix
        if (rnd_q == AES_ROUNDS) begin
            round_out = shifted ^ round_keys_i[rnd_q];
        end else begin
            round_out = mix_columns(shifted) ^ round_keys_i[rnd_q];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= (rnd_q == AES_ROUNDS);
            if (start_i) begin
                rnd_q <= 4'd1;
            end else if (rnd_q == AES_ROUNDS) begin
                rnd_q <= '0;
            end else if (rnd_q != '0) begin
                rnd_q <= rnd_q + 4'd1;
            end
        end
    end

    // state register, initial add-round-key on start
    always_ff @(posedge clk) begin
        if (start_i) begin
            state_q <= plain_text_i ^ round_keys_i[0];
        end else if (rnd_q != '0) begin
            state_q <= round_out;
        end
    end

    assign cipher_text_o = state_q;
    assign done_o        = done_q;
    assign ready_o       = (rnd_q == '0);

    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o
    ) else $error("encrypt done held for more than one cycle");

endmodule

// File: hw/aes128_decrypt.sv
`timescale 1ns/1ps

module aes128_decrypt
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       start_i,
    input  aes_rkeys_t round_keys_i,
    input  aes_block_t cipher_text_i,

    output aes_block_t plain_text_o,
    output logic       done_o,
    output logic       ready_o
);

    aes_block_t state_q;
    // 0 when idle, otherwise the round performed on the next edge
    aes_round_t rnd_q;
    logic       done_q;

    // round keys are walked from 10 down to 0
    aes_round_t key_idx;
    aes_block_t unmixed;
    aes_block_t round_out;

    always_comb begin
        key_idx = AES_ROUNDS - rnd_q;
        unmixed = inv_sub_bytes(inv_shift_rows(state_q)) ^ round_keys_i[key_idx];
        if (rnd_q == AES_ROUNDS) begin
            round_out = unmixed;
        end else begin
            round_out = inv_mix_columns(unmixed);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= (rnd_q == AES_ROUNDS);
            if (start_i) begin
                rnd_q <= 4'd1;
            end else if (rnd_q == AES_ROUNDS) begin
                rnd_q <= '0;
            end else if (rnd_q != '0) begin
                rnd_q <= rnd_q + 4'd1;
            end
        end
    end

    // start applies the last round key first
    always_ff @(posedge clk) begin
        if (start_i) begin
            state_q <= cipher_text_i ^ round_keys_i[AES_ROUNDS];
        end else if (rnd_q != '0) begin
            state_q <= round_out;
        end
    end

    assign plain_text_o = state_q;
    assign done_o       = done_q;
    assign ready_o      = (rnd_q == '0);

    a_done_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o
    ) else $error("decrypt done held for more than one cycle");

endmodule

// File: hw/aes128_core.sv
`timescale 1ns/1ps

module aes128_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // commands, one at a time
    input  logic       start_enc_i,
    input  logic       start_dec_i,
    input  logic       load_key_i,

    // key or block, depending on the command
    input  aes_block_t data_i,

    output aes_block_t data_o,
    output logic       ready_o,
    output logic       done_o
);

    typedef enum logic [1:0] {
        IDLE,
        KEY_EXPAND,
        ENCRYPT,
        DECRYPT
    } core_state_t;

    core_state_t state_q;
    core_state_t state_d;

    aes_rkeys_t round_keys;
    aes_block_t enc_text;
    aes_block_t dec_text;
    logic       key_busy;
    logic       enc_ready;
    logic       enc_done;
    logic       dec_ready;
    logic       dec_done;

    logic       accept;
    logic       load_go;
    logic       enc_go;
    logic       dec_go;

    // priority load, then encrypt, then decrypt
    assign accept  = ready_o && (state_q == IDLE);
    assign load_go = accept && load_key_i;
    assign enc_go  = accept && !load_key_i && start_enc_i;
    assign dec_go  = accept && !load_key_i && !start_enc_i && start_dec_i;

    aes128_key_expand u_key_exp (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_i       (load_go),
        .key_i        (data_i),
        .round_keys_o (round_keys),
        .busy_o       (key_busy)
    );

    aes128_encrypt u_enc_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (enc_go),
        .round_keys_i  (round_keys),
        .plain_text_i  (data_i),
        .cipher_text_o (enc_text),
        .done_o        (enc_done),
        .ready_o       (enc_ready)
    );

    aes128_decrypt u_dec_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (dec_go),
        .round_keys_i  (round_keys),
        .cipher_text_i (data_i),
        .plain_text_o  (dec_text),
        .done_o        (dec_done),
        .ready_o       (dec_ready)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (load_go) begin
                    state_d = KEY_EXPAND;
                end else if (enc_go) begin
                    state_d = ENCRYPT;
                end else if (dec_go) begin
                    state_d = DECRYPT;
                end
            end
            KEY_EXPAND: begin
                if (!key_busy) begin
                    state_d = IDLE;
                end
            end
            ENCRYPT: begin
                if (enc_done) begin
                    state_d = IDLE;
                end
            end
            DECRYPT: begin
                if (dec_done) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            ready_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // also rises on the edge that returns the FSM to IDLE
            ready_o <= enc_ready && dec_ready && !key_busy &&
                       (state_q == IDLE || state_d == IDLE);
        end
    end

    // result only visible during the done cycle
    always_comb begin
        done_o = enc_done || dec_done;
        data_o = '0;
        if (enc_done) begin
            data_o = enc_text;
        end else if (dec_done) begin
            data_o = dec_text;
        end
    end

    a_one_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(start_enc_i && start_dec_i)
    ) else $error("encrypt and decrypt requested together");

    a_one_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(enc_done && dec_done)
    ) else $error("both cipher units signalled done");

endmodule

// File: verif/aes128_tb.sv
`timescale 1ns/1ps

module aes128_tb
    import aes_pkg::*;
;

    localparam int READY_TIMEOUT = 50;
    localparam int DONE_TIMEOUT  = 40;
    localparam int OP_LOAD = 0;
    localparam int OP_ENC  = 1;
    localparam int OP_DEC  = 2;

    // FIPS-197 appendix C.1 vector
    localparam aes_block_t KAT_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_block_t KAT_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_block_t KAT_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic       clk;
    logic       rst_n;
    logic       start_enc_i;
    logic       start_dec_i;
    logic       load_key_i;
    aes_block_t data_i;
    aes_block_t data_o;
    logic       ready_o;
    logic       done_o;

    logic [31:0] lfsr_q = 32'h5cf5;
    int          err_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    aes128_core uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_enc_i (start_enc_i),
        .start_dec_i (start_dec_i),
        .load_key_i  (load_key_i),
        .data_i      (data_i),
        .data_o      (data_o),
        .ready_o     (ready_o),
        .done_o      (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void report_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        err_count++;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_block(output aes_block_t b);
        for (int i = 0; i < 128; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b[i]   = lfsr_q[0];
        end
    endtask

    function automatic void check_block(input aes_block_t got, input aes_block_t exp,
                                        input string what);
        assert (got === exp)
            else report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endfunction

    function automatic void check_edges(input int got, input int exp, input string what);
        assert (got == exp)
            else report_mismatch($sformatf("%s took %0d edges, expected %0d", what, got, exp));
    endfunction

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!ready_o && n < READY_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ready_o) begin
            $display("Timeout: ready_o never went high before %s", what);
            err_count++;
        end
    endtask

    // edges are counted from the accepting edge, which is edge 1
    task automatic run_op(input int op, input aes_block_t din, input int stray_edge,
                          output aes_block_t dout, output int edges);
        logic finished;
        wait_ready("a new command");
        @(posedge clk);
        load_key_i  <= (op == OP_LOAD);
        start_enc_i <= (op == OP_ENC);
        start_dec_i <= (op == OP_DEC);
        data_i      <= din;
        finished = 1'b0;
        edges    = 0;
        dout     = '0;
        while (!finished && edges < DONE_TIMEOUT) begin
            @(posedge clk);
            edges++;
            load_key_i  <= 1'b0;
            start_enc_i <= 1'b0;
            // a start while the core is busy must be ignored
            start_dec_i <= (stray_edge > 0 && edges == stray_edge);
            @(negedge clk);
            if (op == OP_LOAD) begin
                finished = (edges > 1 && ready_o);
                assert (!done_o) else report_mismatch("done_o pulsed during key load");
            end else if (done_o) begin
                finished = 1'b1;
                dout     = data_o;
            end else if (edges > 1) begin
                assert (!ready_o) else report_mismatch("ready_o high while cipher busy");
            end
        end
        if (!finished) begin
            $display("Timeout: the core never finished command %0d", op);
            err_count++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %-16s passed", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    a_done_pulse: assert property (@(negedge clk) disable iff (!rst_n) done_o |=> !done_o)
        else report_mismatch("done_o held high for a second cycle");

    a_data_idle: assert property (@(negedge clk) disable iff (!rst_n) !done_o |-> data_o == '0)
        else report_mismatch("data_o nonzero outside done");

    a_busy_in_done: assert property (@(negedge clk) disable iff (!rst_n) done_o |-> !ready_o)
        else report_mismatch("ready_o high during done cycle");

    a_reset_quiet: assert property (@(negedge clk) !rst_n |-> (!ready_o && !done_o))
        else report_mismatch("ready_o or done_o high during reset");

    initial begin
        int         errs;
        int         edges;
        aes_block_t res;
        aes_block_t ct;
        aes_block_t key;
        aes_block_t blk;

        rst_n       = 1'b0;
        start_enc_i = 1'b0;
        start_dec_i = 1'b0;
        load_key_i  = 1'b0;
        data_i      = '0;

        errs = err_count;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!done_o) else report_mismatch("done_o high after reset");
        assert (data_o == '0) else report_mismatch("data_o nonzero after reset");
        wait_ready("the first command");
        end_test("reset", errs);

        errs = err_count;
        run_op(OP_LOAD, KAT_KEY, 0, res, edges);
        check_edges(edges, 12, "key load");
        run_op(OP_ENC, KAT_PT, 0, res, edges);
        check_block(res, KAT_CT, "known-answer encrypt");
        // done ten edges after the accepting edge
        check_edges(edges, 11, "encrypt");
        end_test("kat_encrypt", errs);

        errs = err_count;
        run_op(OP_DEC, KAT_CT, 0, res, edges);
        check_block(res, KAT_PT, "known-answer decrypt");
        check_edges(edges, 11, "decrypt");
        end_test("kat_decrypt", errs);

        errs = err_count;
        for (int i = 0; i < 20; i++) begin
            random_block(key);
            random_block(blk);
            run_op(OP_LOAD, key, 0, res, edges);
            run_op(OP_ENC, blk, 0, ct, edges);
            run_op(OP_DEC, ct, 0, res, edges);
            check_block(res, blk, $sformatf("round trip %0d", i));
        end
        end_test("round_trip", errs);

        errs = err_count;
        random_block(key);
        run_op(OP_LOAD, key, 0, res, edges);
        run_op(OP_ENC, KAT_PT, 0, ct, edges);
        assert (ct !== KAT_CT) else report_mismatch("new key gave the old ciphertext");
        run_op(OP_DEC, ct, 0, res, edges);
        check_block(res, KAT_PT, "decrypt after key reload");
        end_test("key_reload", errs);

        errs = err_count;
        run_op(OP_LOAD, KAT_KEY, 0, res, edges);
        run_op(OP_ENC, KAT_PT, 4, res, edges);
        check_block(res, KAT_CT, "encrypt with stray start");
        check_edges(edges, 11, "encrypt with stray start");
        // the ignored start must not produce a late done
        repeat (14) begin
            @(negedge clk);
            assert (!done_o) else report_mismatch("extra done pulse after stray start");
        end
        end_test("protocol", errs);

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/aes_pkg.sv
hw/aes128_key_expand.sv
hw/aes128_encrypt.sv
hw/aes128_decrypt.sv
hw/aes128_core.sv
verif/aes128_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= aes128_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

test: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
